// File: verilog/pe_cfg_pkg.sv
package pe_cfg_pkg;

    // ====================
    // limits and sizes
    // ====================
    localparam int MAX_R  = 12;
    localparam int MAX_TW = 16;
    localparam int MAX_U  = 4;
    localparam int MAX_PM = 4;

    // input row must fit 64, so (tw-1)*u+r is kept at or below it
    localparam int IPAD_DEPTH = 64;
    localparam int WPAD_DEPTH = MAX_R * MAX_PM;
    localparam int IPAD_AW    = $clog2(IPAD_DEPTH);
    localparam int WPAD_AW    = $clog2(WPAD_DEPTH);

    // index widths of the three loop counters
    localparam int IN_IW  = IPAD_AW + 1;
    localparam int WT_IW  = $clog2(MAX_R + 1);
    localparam int OUT_IW = $clog2(MAX_TW + 1);

    // loop levels, innermost first
    localparam int LV_R = 0;
    localparam int LV_M = 1;
    localparam int LV_T = 2;

    // ====================
    // data types
    // ====================
    typedef logic [7:0]  pix_t;
    typedef logic [5:0]  wt_t;
    typedef logic [19:0] psum_t;

    typedef enum logic {UNSIGNED = 1'b0, SIGNED = 1'b1} num_t;

    typedef struct packed {
        logic [$clog2(MAX_R+1)-1:0]  r;
        logic [$clog2(MAX_TW+1)-1:0] tw;
        logic [$clog2(MAX_U+1)-1:0]  u;
        logic [$clog2(MAX_PM+1)-1:0] pm;
        num_t                        x_numt;
        num_t                        w_numt;
    } pe_conf_t;

    typedef struct packed {
        logic dval;
        logic start;
        logic next;
        logic stall;
        logic reset;
    } pe_inst_t;

    typedef struct packed {
        logic [IN_IW-1:0]         in_len;
        logic [1:0][WT_IW-1:0]    wt;
        logic [2:0][OUT_IW-1:0]   out;
    } loop_sizes_t;

    typedef struct packed {
        logic reset;
        logic dval;
        logic inc;
    } loop_ctl_t;

    // fin marks the final result of a run
    typedef struct packed {
        logic [$clog2(MAX_TW)-1:0] t;
        logic [$clog2(MAX_PM)-1:0] m;
        logic                      fin;
    } out_tag_t;

    typedef struct packed {
        logic [IPAD_AW-1:0] in_addr;
        logic [WPAD_AW-1:0] wt_addr;
        logic               first;
        logic               last;
        out_tag_t           tag;
    } mac_req_t;

    typedef struct packed {
        psum_t    psum;
        out_tag_t tag;
    } psum_out_t;

endpackage

// File: verilog/loop_counter.sv
module loop_counter
    import pe_cfg_pkg::*;
#(
    parameter int NDEPTH = 1,
    parameter int IDXW   = 4
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  loop_ctl_t                   i_ctl,
    input  logic [NDEPTH-1:0][IDXW-1:0] i_size,
    output logic [NDEPTH-1:0][IDXW-1:0] o_idx,
    output logic [NDEPTH-1:0]           o_end
);

    // carry into each level
    logic [NDEPTH-1:0] carry;

    always_comb begin
        carry[0] = i_ctl.dval && i_ctl.inc;
        for (int i = 1; i < NDEPTH; i++) begin
            carry[i] = carry[i-1] && o_end[i-1];
        end
    end

    for (genvar g = 0; g < NDEPTH; g++) begin : g_lvl
        assign o_end[g] = (o_idx[g] == IDXW'(i_size[g] - 1'b1));

        // sizes come from decode, index state lives here
        a_idx_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            i_ctl.dval |-> o_idx[g] < i_size[g]);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_idx <= '0;
        end else if (i_ctl.reset) begin
            o_idx <= '0;
        end else begin
            for (int i = 0; i < NDEPTH; i++) begin
                if (carry[i]) begin
                    o_idx[i] <= o_end[i] ? '0 : o_idx[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/scratch_pad.sv
module scratch_pad #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 64
) (
    input  logic                     i_clk,
    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_waddr,
    input  payload_t                 i_wdata,
    input  logic [$clog2(DEPTH)-1:0] i_raddr,
    output payload_t                 o_rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge i_clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

// File: verilog/mac_unit.sv
module mac_unit
    import pe_cfg_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  pix_t     i_pix,
    input  wt_t      i_wt,
    input  pe_conf_t i_conf,
    input  mac_req_t i_req,
    input  logic     i_req_val,
    output psum_t    o_prod,
    output logic     o_first,
    output logic     o_last,
    output out_tag_t o_tag,
    output logic     o_val
);

    mac_req_t req_q;
    logic     val_q;

    // one extra bit holds the sign or a zero
    logic signed [$bits(pix_t):0] pix_ext;
    logic signed [$bits(wt_t):0]  wt_ext;

    assign pix_ext = {(i_conf.x_numt == SIGNED) && i_pix[$bits(pix_t)-1], i_pix};
    assign wt_ext  = {(i_conf.w_numt == SIGNED) && i_wt[$bits(wt_t)-1], i_wt};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            val_q <= 1'b0;
            o_val <= 1'b0;
        end else begin
            val_q <= i_req_val;
            o_val <= val_q;
        end
    end

    // req_q lines up with pad read data
    always_ff @(posedge i_clk) begin
        req_q   <= i_req;
        o_prod  <= pix_ext * wt_ext;
        o_first <= req_q.first;
        o_last  <= req_q.last;
        o_tag   <= req_q.tag;
    end

endmodule

// File: verilog/psum_accum.sv
module psum_accum
    import pe_cfg_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  psum_t     i_prod,
    input  logic      i_first,
    input  logic      i_last,
    input  out_tag_t  i_tag,
    input  logic      i_val,
    input  logic      i_out_ack,
    output psum_out_t o_out,
    output logic      o_out_rdy,
    output logic      o_busy,
    output logic      o_done_tag_last
);

    psum_t acc;
    psum_t sum_now;
    logic  close;

    // first tap restarts the sum
    assign sum_now = i_first ? i_prod : acc + i_prod;
    assign close   = i_val && i_last;

    always_ff @(posedge i_clk) begin
        if (i_val) begin
            acc <= sum_now;
        end
        if (close) begin
            o_out <= '{psum: sum_now, tag: i_tag};
        end
    end

    // ====================
    // output handshake
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_rdy <= 1'b0;
        end else if (close) begin
            o_out_rdy <= 1'b1;
        end else if (i_out_ack) begin
            o_out_rdy <= 1'b0;
        end
    end

    assign o_busy          = o_out_rdy || close;
    assign o_done_tag_last = o_out_rdy && i_out_ack && o_out.tag.fin;

    // issue side must hold back while the output register is occupied
    a_no_overrun: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        close |-> !o_out_rdy);

endmodule

// File: verilog/data_path_controller.sv
module data_path_controller
    import pe_cfg_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_ce,
    input  logic               i_loop_rst,
    input  loop_sizes_t        i_sizes,
    input  pe_conf_t           i_conf,
    input  logic               i_in_rdy,
    input  logic               i_wt_rdy,
    input  logic               i_busy,
    output logic               o_in_ack,
    output logic               o_wt_ack,
    output logic               o_in_we,
    output logic [IPAD_AW-1:0] o_in_waddr,
    output logic               o_wt_we,
    output logic [WPAD_AW-1:0] o_wt_waddr,
    output mac_req_t           o_req,
    output logic               o_req_val,
    output logic               o_last_done
);

    loop_ctl_t in_ctl;
    loop_ctl_t wt_ctl;
    loop_ctl_t out_ctl;

    logic [0:0][IN_IW-1:0]  in_idx;
    logic [1:0][WT_IW-1:0]  wt_idx;
    logic [2:0][OUT_IW-1:0] out_idx;
    logic [0:0]             in_end;
    logic [1:0]             wt_end;
    logic [2:0]             out_end;

    // run progress
    logic in_done;
    logic wt_done;
    logic out_done;
    logic last_pend;

    logic [IN_IW-1:0]   in_cnt;
    logic [IN_IW-1:0]   rd_in;
    logic [WPAD_AW-1:0] wt_total;
    logic [WPAD_AW-1:0] wt_cnt;
    logic [WPAD_AW-1:0] rd_wt;
    logic               issue;

    // ====================
    // loop counters
    // ====================
    assign in_ctl  = '{reset: i_loop_rst, dval: i_ce, inc: o_in_we};
    assign wt_ctl  = '{reset: i_loop_rst, dval: i_ce, inc: o_wt_we};
    assign out_ctl = '{reset: i_loop_rst, dval: i_ce, inc: issue};

    loop_counter #(.NDEPTH(1), .IDXW(IN_IW)) u_in_loop (
        .i_clk,
        .i_rst_n,
        .i_ctl  (in_ctl),
        .i_size (i_sizes.in_len),
        .o_idx  (in_idx),
        .o_end  (in_end)
    );

    // weights filter-major, taps inner
    loop_counter #(.NDEPTH(2), .IDXW(WT_IW)) u_wt_loop (
        .i_clk,
        .i_rst_n,
        .i_ctl  (wt_ctl),
        .i_size (i_sizes.wt),
        .o_idx  (wt_idx),
        .o_end  (wt_end)
    );

    // pixel t outer, filter m, tap r inner
    loop_counter #(.NDEPTH(3), .IDXW(OUT_IW)) u_out_loop (
        .i_clk,
        .i_rst_n,
        .i_ctl  (out_ctl),
        .i_size (i_sizes.out),
        .o_idx  (out_idx),
        .o_end  (out_end)
    );

    // ====================
    // stream acks
    // ====================
    assign o_in_ack   = i_ce && !i_loop_rst && !in_done;
    assign o_wt_ack   = i_ce && !i_loop_rst && !wt_done;
    assign o_in_we    = i_in_rdy && o_in_ack;
    assign o_wt_we    = i_wt_rdy && o_wt_ack;
    assign o_in_waddr = in_idx[0][IPAD_AW-1:0];
    assign o_wt_waddr = wt_idx[LV_M] * i_conf.r + wt_idx[LV_R];

    // number of items already written
    assign in_cnt   = in_done ? i_sizes.in_len : in_idx[0];
    assign wt_total = i_conf.pm * i_conf.r;
    assign wt_cnt   = wt_done ? wt_total : o_wt_waddr;

    // ====================
    // catch-up and issue
    // ====================
    assign rd_in = out_idx[LV_T] * i_conf.u + out_idx[LV_R];
    assign rd_wt = out_idx[LV_M] * i_conf.r + out_idx[LV_R];

    assign issue = i_ce && !i_loop_rst && !out_done && !i_busy && !last_pend &&
                   (in_cnt > rd_in) && (wt_cnt > rd_wt);

    always_comb begin
        o_req.in_addr = rd_in[IPAD_AW-1:0];
        o_req.wt_addr = rd_wt;
        o_req.first   = (out_idx[LV_R] == '0);
        o_req.last    = out_end[LV_R];
        o_req.tag.t   = out_idx[LV_T][$bits(o_req.tag.t)-1:0];
        o_req.tag.m   = out_idx[LV_M][$bits(o_req.tag.m)-1:0];
        o_req.tag.fin = &out_end;
    end

    assign o_req_val = issue;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in_done   <= 1'b0;
            wt_done   <= 1'b0;
            out_done  <= 1'b0;
            last_pend <= 1'b0;
        end else begin
            // covers the read stage before psum_accum sees the last tap
            last_pend <= issue && o_req.last;
            if (i_loop_rst) begin
                in_done  <= 1'b0;
                wt_done  <= 1'b0;
                out_done <= 1'b0;
            end else begin
                if (o_in_we && in_end[0]) in_done <= 1'b1;
                if (o_wt_we && &wt_end) wt_done <= 1'b1;
                if (issue && &out_end) out_done <= 1'b1;
            end
        end
    end

    // all taps issued and the final result has left
    assign o_last_done = out_done && !i_busy && !last_pend;

    // pad read addresses stay below the pad write pointers
    a_rd_below_wr: assert property (@(posedge i_clk) disable iff (!i_rst_n || i_loop_rst)
        o_req_val |-> (in_done || o_req.in_addr < o_in_waddr) &&
                      (wt_done || o_req.wt_addr < o_wt_waddr));

endmodule

// File: verilog/pe_decode.sv
module pe_decode
    import pe_cfg_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  pe_inst_t    i_inst,
    input  pe_conf_t    i_conf,
    input  logic        i_last_done,
    output logic        o_ce,
    output logic        o_loop_rst,
    output loop_sizes_t o_sizes
);

    typedef enum logic [2:0] {IDLE, INIT, WORK, STALL} state_t;

    state_t state;
    state_t state_nxt;
    logic   cmd_start;
    logic   cmd_next;
    logic   cmd_stall;
    logic   cmd_reset;

    // instruction fields only count with dval
    assign cmd_start = i_inst.dval && i_inst.start;
    assign cmd_next  = i_inst.dval && i_inst.next;
    assign cmd_stall = i_inst.dval && i_inst.stall;
    assign cmd_reset = i_inst.dval && i_inst.reset;

    // ====================
    // main FSM
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (cmd_start) state_nxt = INIT;
            end
            INIT: begin
                state_nxt = cmd_reset ? IDLE : WORK;
            end
            WORK: begin
                if ((cmd_reset && i_inst.start) || cmd_next) state_nxt = INIT;
                else if (cmd_reset || i_last_done) state_nxt = IDLE;
                else if (cmd_stall) state_nxt = STALL;
            end
            STALL: begin
                // results may still drain while stalled
                if (cmd_reset || i_last_done) state_nxt = IDLE;
                else if (i_inst.dval && !i_inst.stall) state_nxt = WORK;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign o_ce       = (state == WORK);
    assign o_loop_rst = (state == INIT) || cmd_reset;

    // ====================
    // loop bounds
    // ====================
    always_comb begin
        o_sizes.in_len    = (IN_IW'(i_conf.tw) - 1'b1) * i_conf.u + i_conf.r;
        o_sizes.wt[LV_R]  = WT_IW'(i_conf.r);
        o_sizes.wt[LV_M]  = WT_IW'(i_conf.pm);
        o_sizes.out[LV_R] = OUT_IW'(i_conf.r);
        o_sizes.out[LV_M] = OUT_IW'(i_conf.pm);
        o_sizes.out[LV_T] = OUT_IW'(i_conf.tw);
    end

    a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(state) && state inside {IDLE, INIT, WORK, STALL});

endmodule

// File: verilog/pe_top.sv
module pe_top
    import pe_cfg_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  pe_conf_t  i_conf,
    input  pe_inst_t  i_inst,
    input  logic      i_in_rdy,
    input  pix_t      i_in_data,
    output logic      o_in_ack,
    input  logic      i_wt_rdy,
    input  wt_t       i_wt_data,
    output logic      o_wt_ack,
    output logic      o_out_rdy,
    output psum_out_t o_out,
    input  logic      i_out_ack,
    output logic      o_done
);

    logic               ce;
    logic               loop_rst;
    loop_sizes_t        sizes;
    logic               last_done;
    logic               in_we;
    logic [IPAD_AW-1:0] in_waddr;
    logic               wt_we;
    logic [WPAD_AW-1:0] wt_waddr;
    mac_req_t           req;
    logic               req_val;
    pix_t               pix_rd;
    wt_t                wt_rd;
    psum_t              prod;
    logic               prod_first;
    logic               prod_last;
    out_tag_t           prod_tag;
    logic               prod_val;
    logic               busy;

    // ====================
    // decode
    // ====================
    pe_decode u_decode (
        .i_clk,
        .i_rst_n,
        .i_inst,
        .i_conf,
        .i_last_done (last_done),
        .o_ce        (ce),
        .o_loop_rst  (loop_rst),
        .o_sizes     (sizes)
    );

    // ====================
    // execute
    // ====================
    data_path_controller u_dpc (
        .i_clk,
        .i_rst_n,
        .i_ce        (ce),
        .i_loop_rst  (loop_rst),
        .i_sizes     (sizes),
        .i_conf,
        .i_in_rdy,
        .i_wt_rdy,
        .i_busy      (busy),
        .o_in_ack,
        .o_wt_ack,
        .o_in_we     (in_we),
        .o_in_waddr  (in_waddr),
        .o_wt_we     (wt_we),
        .o_wt_waddr  (wt_waddr),
        .o_req       (req),
        .o_req_val   (req_val),
        .o_last_done (last_done)
    );

    scratch_pad #(.payload_t(pix_t), .DEPTH(IPAD_DEPTH)) u_ipad (
        .i_clk,
        .i_we    (in_we),
        .i_waddr (in_waddr),
        .i_wdata (i_in_data),
        .i_raddr (req.in_addr),
        .o_rdata (pix_rd)
    );

    scratch_pad #(.payload_t(wt_t), .DEPTH(WPAD_DEPTH)) u_wpad (
        .i_clk,
        .i_we    (wt_we),
        .i_waddr (wt_waddr),
        .i_wdata (i_wt_data),
        .i_raddr (req.wt_addr),
        .o_rdata (wt_rd)
    );

    mac_unit u_mac (
        .i_clk,
        .i_rst_n,
        .i_pix     (pix_rd),
        .i_wt      (wt_rd),
        .i_conf,
        .i_req     (req),
        .i_req_val (req_val),
        .o_prod    (prod),
        .o_first   (prod_first),
        .o_last    (prod_last),
        .o_tag     (prod_tag),
        .o_val     (prod_val)
    );

    // ====================
    // result
    // ====================
    psum_accum u_accum (
        .i_clk,
        .i_rst_n,
        .i_prod          (prod),
        .i_first         (prod_first),
        .i_last          (prod_last),
        .i_tag           (prod_tag),
        .i_val           (prod_val),
        .i_out_ack,
        .o_out,
        .o_out_rdy,
        .o_busy          (busy),
        .o_done_tag_last (o_done)
    );

endmodule

// File: dv/tb_clkgen.sv
module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 4;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

// File: dv/pe_tb.sv
module pe_tb
    import pe_cfg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          STALL_LEN = 16;
    localparam int          FLUSH_LEN = 10;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;
    // taps per test, the reset test runs twice
    localparam int          TAP_TOTAL = 12 + 60 + 60 + 48 + 48 + 2 * 24;
    localparam int          TIMEOUT_CYCLES = TAP_TOTAL * 8 + 600;

    logic      clk;
    logic      rst_n;
    pe_conf_t  conf;
    pe_inst_t  inst;
    logic      in_rdy;
    pix_t      in_data;
    logic      in_ack;
    logic      wt_rdy;
    wt_t       wt_data;
    logic      wt_ack;
    logic      out_rdy;
    psum_out_t result;
    logic      out_ack;
    logic      done;

    pix_t        pix_mem [IPAD_DEPTH];
    wt_t         wt_mem  [WPAD_DEPTH];
    psum_out_t   exp_res [MAX_TW * MAX_PM];
    int          n_exp;
    logic [15:0] lfsr_state = 16'h0001;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycle_cnt = 0;

    tb_clkgen u_clkgen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    pe_top dut0 (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_conf    (conf),
        .i_inst    (inst),
        .i_in_rdy  (in_rdy),
        .i_in_data (in_data),
        .o_in_ack  (in_ack),
        .i_wt_rdy  (wt_rdy),
        .i_wt_data (wt_data),
        .o_wt_ack  (wt_ack),
        .o_out_rdy (out_rdy),
        .o_out     (result),
        .i_out_ack (out_ack),
        .o_done    (done)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] lfsr_take(input int n_bits);
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < n_bits; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    function automatic pe_conf_t make_conf(input int r, input int tw, input int u,
                                           input int pm, input num_t xn, input num_t wn);
        pe_conf_t c;
        c.r      = r[$clog2(MAX_R+1)-1:0];
        c.tw     = tw[$clog2(MAX_TW+1)-1:0];
        c.u      = u[$clog2(MAX_U+1)-1:0];
        c.pm     = pm[$clog2(MAX_PM+1)-1:0];
        c.x_numt = xn;
        c.w_numt = wn;
        return c;
    endfunction

    // raw operand of a given width read under its number mode
    function automatic int operand_val(input int raw, input int width, input num_t nt);
        if (nt == SIGNED && raw[width-1]) begin
            return raw - (1 << width);
        end
        return raw;
    endfunction

    task automatic check_psum(input string name, input psum_out_t got, input psum_out_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s got psum 0x%h tag 0x%h expected psum 0x%h tag 0x%h at %0t",
                     name, got.psum, got.tag, exp.psum, exp.tag, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        n_checks++;
        if (!cond) begin
            n_errors++;
            $display("%s at %0t", what, $time);
        end
    endtask

    task automatic fill_streams();
        for (int i = 0; i < IPAD_DEPTH; i++) begin
            pix_mem[i] = pix_t'(lfsr_take($bits(pix_t)));
        end
        for (int i = 0; i < WPAD_DEPTH; i++) begin
            wt_mem[i] = wt_t'(lfsr_take($bits(wt_t)));
        end
    endtask

    // sum over r of in[t*U+r] * w[m*R+r], pixel outer, filter inner
    task automatic build_expected(input pe_conf_t c);
        int        acc;
        psum_out_t e;
        n_exp = 0;
        for (int t = 0; t < int'(c.tw); t++) begin
            for (int m = 0; m < int'(c.pm); m++) begin
                acc = 0;
                for (int r = 0; r < int'(c.r); r++) begin
                    acc += operand_val(int'(pix_mem[t * int'(c.u) + r]), $bits(pix_t), c.x_numt)
                         * operand_val(int'(wt_mem[m * int'(c.r) + r]), $bits(wt_t), c.w_numt);
                end
                e.psum    = acc[$bits(psum_t)-1:0];
                e.tag.t   = t[$clog2(MAX_TW)-1:0];
                e.tag.m   = m[$clog2(MAX_PM)-1:0];
                e.tag.fin = (t == int'(c.tw) - 1) && (m == int'(c.pm) - 1);
                exp_res[n_exp] = e;
                n_exp++;
            end
        end
    endtask

    task automatic drive_quiet();
        inst    = '0;
        in_rdy  = 1'b0;
        in_data = '0;
        wt_rdy  = 1'b0;
        wt_data = '0;
        out_ack = 1'b0;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_flag("o_in_ack", in_ack, 1'b0);
        check_flag("o_wt_ack", wt_ack, 1'b0);
        check_flag("o_out_rdy", out_rdy, 1'b0);
        check_flag("o_done", done, 1'b0);
    endtask

    // streams offered, outputs drained, acks must stay low
    task automatic flush_after_reset();
        repeat (FLUSH_LEN) begin
            @(posedge clk);
            #1;
            inst    = '0;
            in_rdy  = 1'b1;
            wt_rdy  = 1'b1;
            out_ack = 1'b1;
            @(negedge clk);
            check_flag("o_in_ack", in_ack, 1'b0);
            check_flag("o_wt_ack", wt_ack, 1'b0);
            check_flag("o_done", done, 1'b0);
        end
    endtask

    // ====================
    // job engine
    // ====================
    task automatic run_job(input pe_conf_t c, input bit gaps, input int stall_at,
                           input int reset_at);
        int        in_len;
        int        n_wt;
        int        in_pos;
        int        wt_pos;
        int        res_pos;
        int        stall_t;
        bit        aborted;
        bit        held;
        bit        taken;
        psum_out_t held_val;

        in_len   = (int'(c.tw) - 1) * int'(c.u) + int'(c.r);
        n_wt     = int'(c.r) * int'(c.pm);
        in_pos   = 0;
        wt_pos   = 0;
        res_pos  = 0;
        stall_t  = -1;
        aborted  = 1'b0;
        held     = 1'b0;
        held_val = '0;
        build_expected(c);

        @(posedge clk);
        #1;
        drive_quiet();
        conf       = c;
        inst.dval  = 1'b1;
        inst.start = 1'b1;

        while (res_pos < n_exp && !aborted) begin
            @(posedge clk);
            #1;
            inst = '0;
            if (stall_t >= 0) begin
                stall_t++;
            end
            if (stall_t < 0 && res_pos == stall_at) begin
                inst.dval  = 1'b1;
                inst.stall = 1'b1;
                stall_t    = 0;
            end else if (stall_t == STALL_LEN) begin
                // dval alone releases the stall
                inst.dval = 1'b1;
            end else if (res_pos == reset_at) begin
                inst.dval  = 1'b1;
                inst.reset = 1'b1;
                aborted    = 1'b1;
            end
            in_rdy  = (in_pos < in_len) && (!gaps || lfsr_take(1) != 0);
            in_data = (in_pos < in_len) ? pix_mem[in_pos] : '0;
            wt_rdy  = (wt_pos < n_wt) && (!gaps || lfsr_take(1) != 0);
            wt_data = (wt_pos < n_wt) ? wt_mem[wt_pos] : '0;
            out_ack = !gaps || lfsr_take(1) != 0;

            @(negedge clk);
            taken = out_rdy && out_ack;
            check_flag("o_done", done, taken && res_pos == n_exp - 1);
            // unacknowledged result must hold
            if (held) begin
                check_flag("o_out_rdy", out_rdy, 1'b1);
                check_psum("o_out", result, held_val);
            end
            if (taken) begin
                check_psum("o_out", result, exp_res[res_pos]);
                res_pos++;
            end
            held     = out_rdy && !out_ack;
            held_val = result;
            if (in_rdy && in_ack) begin
                in_pos++;
            end
            if (wt_rdy && wt_ack) begin
                wt_pos++;
            end
            if (aborted || (stall_t >= 1 && stall_t <= STALL_LEN)) begin
                check_flag("o_in_ack", in_ack, 1'b0);
                check_flag("o_wt_ack", wt_ack, 1'b0);
            end
            // in-flight taps have drained by now
            if (stall_t >= 5 && stall_t <= STALL_LEN) begin
                check_flag("o_out_rdy", out_rdy, 1'b0);
            end
        end

        if (aborted) begin
            flush_after_reset();
        end else begin
            expect_true(in_pos == in_len, "input stream was not fully consumed");
            expect_true(wt_pos == n_wt, "weight stream was not fully consumed");
            repeat (3) begin
                @(posedge clk);
                #1;
                drive_quiet();
                @(negedge clk);
                check_flag("o_done", done, 1'b0);
                check_flag("o_in_ack", in_ack, 1'b0);
                check_flag("o_wt_ack", wt_ack, 1'b0);
            end
        end
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic unsigned_basic();
        fill_streams();
        run_job(make_conf(3, 4, 1, 1, UNSIGNED, UNSIGNED), 1'b0, -1, -1);
    endtask

    task automatic stride_filters();
        fill_streams();
        run_job(make_conf(4, 5, 2, 3, UNSIGNED, UNSIGNED), 1'b0, -1, -1);
    endtask

    task automatic signed_values();
        fill_streams();
        // most negative pixel and a weight of minus one
        pix_mem[0] = 8'h80;
        wt_mem[1]  = 6'h3f;
        run_job(make_conf(5, 6, 1, 2, SIGNED, SIGNED), 1'b0, -1, -1);
    endtask

    task automatic stream_gaps();
        fill_streams();
        run_job(make_conf(3, 8, 3, 2, UNSIGNED, SIGNED), 1'b1, -1, -1);
    endtask

    task automatic stall_release();
        fill_streams();
        run_job(make_conf(4, 6, 1, 2, SIGNED, UNSIGNED), 1'b0, 3, -1);
    endtask

    task automatic reset_restart();
        pe_conf_t c;
        c = make_conf(3, 4, 2, 2, UNSIGNED, UNSIGNED);
        fill_streams();
        run_job(c, 1'b0, -1, 2);
        // fresh data so stale pad contents would show
        fill_streams();
        run_job(c, 1'b0, -1, -1);
    endtask

    initial begin
        drive_quiet();
        conf = '0;
        check_reset_state();
        wait (rst_n === 1'b1);
        unsigned_basic();
        stride_filters();
        signed_values();
        stream_gaps();
        stall_release();
        reset_restart();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/pe_cfg_pkg.sv
verilog/loop_counter.sv
verilog/scratch_pad.sv
verilog/mac_unit.sv
verilog/psum_accum.sv
verilog/data_path_controller.sv
verilog/pe_decode.sv
verilog/pe_top.sv
dv/tb_clkgen.sv
dv/pe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module pe_tb -f list.f -o pe_sim &&
./obj_dir/pe_sim | tee /dev/stderr | grep -q "Regression passed" &&
echo "run_sim: simulation ok" ||
{ echo "run_sim: simulation not ok"; exit 1; }
